//--- Bender.yml
package:
  name: xm_host_port

export_include_dirs:
  - .

sources:
  - xm_pkg.sv
  - ms_timer.sv
  - vram_clear.sv
  - vram_port.sv
  - xm_reg_file.sv
  - xm_top.sv
  - target: test
    files:
      - xm_checker.sv
      - tb_xm_top.sv

//--- ms_timer.sv
// free-running tick timer with a cycle divider, read through TIMER
`timescale 1ns/1ns
`include "xm_settings.svh"

module ms_timer (
    input  logic          clk,
    input  logic          reset_i,
    output xm_pkg::word_t count_o       // wraps at 16 bits
);
    import xm_pkg::*;

    word_t frac;                        // cycles into the current tick

    always_ff @(posedge clk) begin
        if (reset_i) begin
            frac    <= '0;
            count_o <= '0;
        end else if (frac == word_t'(`XM_TIMER_DIV - 1)) begin
            frac    <= '0;
            count_o <= count_o + 1'b1;
        end else begin
            frac    <= frac + 1'b1;
        end
    end

endmodule

//--- project.f
+incdir+.
xm_pkg.sv
ms_timer.sv
vram_clear.sv
vram_port.sv
xm_reg_file.sv
xm_top.sv
xm_checker.sv
tb_xm_top.sv

//--- tb_xm_top.sv
// testbench for the host port, random register traffic against a VRAM model
`timescale 1ns/1ns
`include "xm_settings.svh"

module tb_xm_top;
    import xm_pkg::*;

    localparam int N_WORDS = 16;                    // words per stream test
    localparam int N_OPS   = 4 * N_WORDS + 30;
    localparam int LIMIT   = (`XM_CLEAR_WORDS + N_OPS * 20) * 3;

    logic clk, reset_i, bus_wr_strobe_i, bus_rd_strobe_i, bus_bytesel_i, vgen_sel_i;
    reg_num_t bus_reg_num_i;
    byte_t bus_data_i, bus_data_o;
    word_t vram_data_i, vram_data_o;
    vaddr_t vram_addr_o;
    logic vram_sel_o, vram_wr_o;
    nib_t intr_mask_o, intr_clear_o;
    word_t vram [0:65535];
    int wr_grants = 0;
    int rd_grants = 0;
    time sample_t;

    xm_top xm_top_inst (.*);
    xm_checker check_inst (.clk, .reset_i, .intr_clear_i(intr_clear_o));

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // VRAM model writes on a granted edge and answers reads one edge later
    always @(posedge clk) begin
        if (vram_sel_o && !vgen_sel_i) begin
            if (vram_wr_o) begin
                vram[vram_addr_o] <= vram_data_o;
                wr_grants++;
            end else begin
                vram_data_i <= vram[vram_addr_o];
                rd_grants++;
            end
        end
        vgen_sel_i <= ($urandom % 3) == 0;          // video steals about a third
    end

    initial begin
        repeat (LIMIT) @(posedge clk);
        $display("watchdog: the run did not finish in %0d cycles", LIMIT);
        $display("TEST FAILED");
        $finish;
    end

    task automatic write_byte(input reg_num_t r, input logic sel, input byte_t d);
        @(posedge clk);
        bus_reg_num_i <= r;
        bus_bytesel_i <= sel;
        bus_data_i <= d;
        bus_wr_strobe_i <= 1'b1;
        @(posedge clk);
        bus_wr_strobe_i <= 1'b0;
    endtask

    task automatic write_word(input reg_num_t r, input word_t w);
        write_byte(r, 1'b0, w[15:8]);
        write_byte(r, 1'b1, w[7:0]);
    endtask

    task automatic read_byte(input reg_num_t r, input logic sel, input logic strobe,
                             output byte_t d);
        @(posedge clk);
        bus_reg_num_i <= r;
        bus_bytesel_i <= sel;
        bus_rd_strobe_i <= strobe;
        @(negedge clk);
        d = bus_data_o;                             // mux settled mid-cycle
        sample_t = $time;
        @(posedge clk);
        bus_rd_strobe_i <= 1'b0;
    endtask

    task automatic read_word(input reg_num_t r, output word_t w);
        read_byte(r, 1'b0, 1'b0, w[15:8]);
        read_byte(r, 1'b1, 1'b0, w[7:0]);
    endtask

    // wait for the grant counter to move past n0, then for the completion to land
    task automatic wait_grant(input logic wr, input int n0);
        int n;
        n = 0;
        while ((wr ? wr_grants : rd_grants) == n0 && n < 60) begin
            @(posedge clk);
            n++;
        end
        if (n >= 60) check_inst.report_failure(wr ? "VRAM write never granted"
                                                   : "VRAM read never granted");
        repeat (4) @(posedge clk);
    endtask

    initial begin
        word_t w, incr, a_wr, a_rd, r_incr;
        byte_t b, b2;
        nib_t mask;
        time t1;
        int n0, cyc, d;
        void'($urandom(17743));
        for (int i = 0; i < 65536; i++) vram[i] = word_t'(i) ^ 16'h5a5a;
        reset_i = 1'b1;
        {bus_wr_strobe_i, bus_rd_strobe_i, bus_bytesel_i, vgen_sel_i} = '0;
        bus_reg_num_i = XM_SYS_CTRL;
        bus_data_i = '0;
        vram_data_i = '0;
        repeat (2) @(posedge clk);
        reset_i <= 1'b0;

        // boot clear
        read_byte(XM_SYS_CTRL, 1'b1, 1'b0, b);
        check_inst.compare("busy after reset", 1, b[7]);
        n0 = 0;
        while (b[7] && n0 < `XM_CLEAR_WORDS * 4) begin
            read_byte(XM_SYS_CTRL, 1'b1, 1'b0, b);
            n0++;
        end
        if (b[7]) check_inst.report_failure("boot clear never finished");
        for (int a = 0; a < `XM_CLEAR_WORDS; a++) begin
            check_inst.model_mem[a] = `XM_CLEAR_DATA;
            check_inst.compare($sformatf("vram[%0d]", a), check_inst.model_mem[a], vram[a]);
        end
        check_inst.end_test("boot_clear");

        // write stream
        incr = $urandom | 16'h0100;
        a_wr = $urandom;
        write_word(XM_WR_INCR, incr);
        write_word(XM_WR_ADDR, a_wr);
        for (int k = 0; k < N_WORDS; k++) begin
            w = $urandom;
            write_byte(XM_DATA, 1'b0, w[15:8]);
            n0 = wr_grants;
            write_byte(($urandom % 2) ? XM_DATA_2 : XM_DATA, 1'b1, w[7:0]);
            wait_grant(1'b1, n0);
            check_inst.model_mem[a_wr] = w;
            check_inst.compare($sformatf("vram[%h]", a_wr), check_inst.model_mem[a_wr],
                               vram[a_wr]);
            a_wr = a_wr + incr;
        end
        check_inst.end_test("write_stream");

        // read stream with prefetch
        r_incr = $urandom | 16'h0100;
        a_rd = $urandom;
        write_word(XM_RD_INCR, r_incr);
        write_byte(XM_RD_ADDR, 1'b0, a_rd[15:8]);
        n0 = rd_grants;
        write_byte(XM_RD_ADDR, 1'b1, a_rd[7:0]);
        wait_grant(1'b0, n0);
        for (int k = 0; k < N_WORDS; k++) begin
            read_byte(XM_DATA, 1'b0, 1'b0, w[15:8]);
            n0 = rd_grants;
            read_byte(($urandom % 2) ? XM_DATA_2 : XM_DATA, 1'b1, 1'b1, w[7:0]);
            wait_grant(1'b0, n0);
            check_inst.compare("DATA", check_inst.model_mem[a_rd], w);
            a_rd = a_rd + r_incr;
        end
        a_rd = a_rd + r_incr;                       // the last prefetch stepped once more
        check_inst.end_test("read_stream");

        // register readback and even-byte rule
        read_word(XM_WR_INCR, w);
        check_inst.compare("WR_INCR", incr, w);
        read_word(XM_WR_ADDR, w);
        check_inst.compare("WR_ADDR", a_wr, w);
        read_word(XM_RD_INCR, w);
        check_inst.compare("RD_INCR", r_incr, w);
        read_word(XM_RD_ADDR, w);
        check_inst.compare("RD_ADDR", a_rd, w);
        b = $urandom;
        write_byte(XM_TIMER, 1'b0, 8'hab);          // tags the holding byte with TIMER
        write_byte(XM_RD_INCR, 1'b1, b);
        read_word(XM_RD_INCR, w);
        check_inst.compare("RD_INCR odd only", {8'h00, b}, w);
        check_inst.end_test("readback");

        // interrupts and timer
        mask = $urandom;
        write_byte(XM_SYS_CTRL, 1'b1, {4'h0, mask});
        @(posedge clk);
        check_inst.compare("intr_mask_o", mask, intr_mask_o);
        read_byte(XM_SYS_CTRL, 1'b1, 1'b0, b);
        check_inst.compare("SYS_CTRL", {4'h0, mask}, b);
        b = $urandom | 1;
        n0 = check_inst.clear_pulses;
        write_byte(XM_TIMER, 1'b1, b);
        repeat (3) @(posedge clk);
        check_inst.compare("intr_clear_o pulses", 1, check_inst.clear_pulses - n0);
        check_inst.compare("intr_clear_o", b[3:0], check_inst.last_clear);
        read_byte(XM_TIMER, 1'b1, 1'b0, b);
        t1 = sample_t;
        repeat (50 + $urandom % 100) @(posedge clk);
        read_byte(XM_TIMER, 1'b1, 1'b0, b2);
        cyc = (sample_t - t1) / 100;
        d = int'(byte_t'(b2 - b)) - cyc / `XM_TIMER_DIV;
        if (d > 1 || d < -1) check_inst.report_failure("timer count off over the interval");
        check_inst.end_test("intr_timer");

        $display("tests %0d, errors %0d", check_inst.tests, check_inst.errors);
        if (check_inst.errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- vram_clear.sv
// boot clear sequencer, fills the first block of VRAM with the clear word
`timescale 1ns/1ns
`include "xm_settings.svh"

module vram_clear (
    input  logic              clk,
    input  logic              reset_i,
    input  logic              grant_i,            // current word written
    output xm_pkg::vram_req_t clear_req_o,
    output logic              busy_o
);
    import xm_pkg::*;

    clear_state_t state;
    vaddr_t       clr_addr;
    logic         last;

    assign last   = (clr_addr == vaddr_t'(`XM_CLEAR_WORDS - 1));
    assign busy_o = (state != CLR_DONE);

    assign clear_req_o = '{
        valid: (state == CLR_RUN),
        wr:    1'b1,
        addr:  clr_addr,
        data:  `XM_CLEAR_DATA
    };

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state    <= CLR_IDLE;
            clr_addr <= '0;
        end else begin
            case (state)
                CLR_IDLE: state <= CLR_RUN;     // start right after reset
                CLR_RUN: begin
                    if (grant_i) begin
                        if (last) begin
                            state <= CLR_DONE;
                        end else begin
                            clr_addr <= clr_addr + 1'b1;
                        end
                    end
                end
                CLR_DONE: ;                     // stays here until reset
                default: state <= CLR_IDLE;
            endcase
        end
    end

endmodule

//--- vram_port.sv
// VRAM access port, arbitrates clear and host requests around video cycles
`timescale 1ns/1ns

module vram_port (
    input  logic              clk,
    input  logic              reset_i,
    input  logic              vgen_sel_i,         // video owns VRAM this cycle
    input  xm_pkg::vram_req_t host_req_i,
    input  xm_pkg::vram_req_t clear_req_i,
    input  xm_pkg::word_t     vram_data_i,
    output logic              vram_sel_o,
    output logic              vram_wr_o,
    output xm_pkg::vaddr_t    vram_addr_o,
    output xm_pkg::word_t     vram_data_o,
    output logic              grant_o,            // clear word accepted
    output logic              rd_done_o,
    output xm_pkg::word_t     rd_word_o,
    output logic              wr_done_o
);
    import xm_pkg::*;

    vram_req_t port_q;          // request driven onto VRAM
    logic      from_clr;        // port_q came from the clear sequencer
    logic      grant;
    logic      cap_rd;          // host read granted, data next edge
    logic      cap_wr;          // host write granted

    assign grant       = port_q.valid && !vgen_sel_i;
    assign grant_o     = grant && from_clr;
    assign vram_sel_o  = port_q.valid;
    assign vram_wr_o   = port_q.wr;
    assign vram_addr_o = port_q.addr;
    assign vram_data_o = port_q.data;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            port_q.valid <= 1'b0;
            port_q.wr    <= 1'b0;
            from_clr     <= 1'b0;
            cap_rd       <= 1'b0;
            cap_wr       <= 1'b0;
            rd_done_o    <= 1'b0;
            wr_done_o    <= 1'b0;
        end else begin
            cap_rd    <= grant && !port_q.wr;
            cap_wr    <= grant && port_q.wr && !from_clr;
            rd_done_o <= cap_rd;
            wr_done_o <= cap_wr;
            if (cap_rd) begin
                rd_word_o <= vram_data_i;       // memory answers one edge after grant
            end
            if (clear_req_i.valid) begin
                // host requests dropped while clearing
                if (grant_o) begin
                    port_q.valid <= 1'b0;       // clear address steps on this edge
                end else if (!port_q.valid) begin
                    port_q   <= clear_req_i;
                    from_clr <= 1'b1;
                end
            end else if (host_req_i.valid) begin
                port_q   <= host_req_i;         // newer request replaces a waiting one
                from_clr <= 1'b0;
            end else if (grant) begin
                port_q.valid <= 1'b0;
            end
        end
    end

    // a blocked access stays on the port until video releases VRAM
    hold_on_vgen_a: assert property (@(posedge clk) disable iff (reset_i)
        vram_sel_o && vgen_sel_i |=> vram_sel_o);

endmodule

//--- xm_checker.sv
// testbench checker, models VRAM contents and interrupt pulses and compares results
`timescale 1ns/1ns

module xm_checker (
    input  logic         clk,
    input  logic         reset_i,
    input  xm_pkg::nib_t intr_clear_i
);
    import xm_pkg::*;

    word_t model_mem [0:65535];     // expected VRAM contents
    int    errors = 0;
    int    tests = 0;
    int    start_errors = 0;        // error count when the current test began
    int    clear_pulses = 0;
    nib_t  last_clear = '0;

    initial begin
        for (int i = 0; i < 65536; i++) begin
            model_mem[i] = word_t'(i) ^ 16'h5a5a;   // same fill as the memory in the bench
        end
    end

    // count cycles with an interrupt clear pulse
    always @(posedge clk) begin
        if (!reset_i && intr_clear_i != '0) begin
            clear_pulses++;
            last_clear = intr_clear_i;
        end
    end

    task automatic compare(input string name, input int exp_v, input int act_v);
        if (exp_v != act_v) begin
            $display("MISMATCH at %0t ns: %s expected %h got %h", $time, name, exp_v, act_v);
            errors++;
        end
    endtask

    task automatic report_failure(input string msg);
        $display("ERROR at %0t ns: %s", $time, msg);
        errors++;
    endtask

    task automatic end_test(input string name);
        tests++;
        $display("%s: %s, %0d errors", name,
                 (errors == start_errors) ? "pass" : "fail", errors - start_errors);
        start_errors = errors;
    endtask

endmodule

//--- xm_pkg.sv
// shared types for the video host port register block
package xm_pkg;

    typedef logic [15:0] word_t;        // VRAM data and register word
    typedef logic [15:0] vaddr_t;       // VRAM word address
    typedef logic [7:0]  byte_t;        // one host bus byte
    typedef logic [3:0]  nib_t;         // interrupt fields

    // host register numbers, 8 to 15 unused
    typedef enum logic [3:0] {
        XM_SYS_CTRL = 4'd0,
        XM_TIMER    = 4'd1,
        XM_RD_INCR  = 4'd2,
        XM_RD_ADDR  = 4'd3,
        XM_WR_INCR  = 4'd4,
        XM_WR_ADDR  = 4'd5,
        XM_DATA     = 4'd6,
        XM_DATA_2   = 4'd7
    } reg_num_t;

    // boot clear sequencer
    typedef enum logic [1:0] {
        CLR_IDLE,
        CLR_RUN,
        CLR_DONE
    } clear_state_t;

    // one VRAM access request
    typedef struct packed {
        logic   valid;                  // request present
        logic   wr;                     // 1 write, 0 read
        vaddr_t addr;
        word_t  data;                   // write data
    } vram_req_t;

endpackage

//--- xm_reg_file.sv
// host register block, assembles bus bytes into words and steers VRAM accesses
`timescale 1ns/1ns
`include "xm_settings.svh"

module xm_reg_file (
    input  logic              clk,
    input  logic              reset_i,
    input  logic              bus_wr_strobe_i,    // one-cycle byte write
    input  logic              bus_rd_strobe_i,    // one-cycle byte read
    input  xm_pkg::reg_num_t  bus_reg_num_i,
    input  logic              bus_bytesel_i,      // 0 even/high, 1 odd/low
    input  xm_pkg::byte_t     bus_data_i,
    input  logic              busy_i,             // boot clear running
    input  xm_pkg::word_t     timer_i,
    input  logic              rd_done_i,
    input  xm_pkg::word_t     rd_word_i,
    input  logic              wr_done_i,
    output xm_pkg::byte_t     bus_data_o,
    output xm_pkg::vram_req_t host_req_o,
    output xm_pkg::nib_t      intr_mask_o,
    output xm_pkg::nib_t      intr_clear_o
);
    import xm_pkg::*;

    vaddr_t   rd_addr;
    word_t    rd_incr;
    vaddr_t   wr_addr;
    word_t    wr_incr;
    word_t    rd_data;          // last word fetched for DATA reads
    byte_t    data_even;        // held high byte for DATA/DATA_2
    byte_t    other_even;       // generic held high byte
    reg_num_t other_reg;        // tag of other_even
    byte_t    even_byte;        // high byte for the odd write in progress
    word_t    mux_word;
    logic     even_wr;
    logic     odd_wr;
    logic     odd_rd;

    assign even_wr   = bus_wr_strobe_i && !bus_bytesel_i;
    assign odd_wr    = bus_wr_strobe_i && bus_bytesel_i;
    assign odd_rd    = bus_rd_strobe_i && bus_bytesel_i;
    assign even_byte = (other_reg == bus_reg_num_i) ? other_even : 8'h00;

    always_comb begin
        case (bus_reg_num_i)
            XM_SYS_CTRL:        mux_word = {8'h00, busy_i, 3'b000, intr_mask_o};
            XM_TIMER:           mux_word = timer_i;
            XM_RD_INCR:         mux_word = rd_incr;
            XM_RD_ADDR:         mux_word = rd_addr;
            XM_WR_INCR:         mux_word = wr_incr;
            XM_WR_ADDR:         mux_word = wr_addr;
            XM_DATA, XM_DATA_2: mux_word = rd_data;
            default:            mux_word = '0;
        endcase
    end

    assign bus_data_o = bus_bytesel_i ? mux_word[7:0] : mux_word[15:8];

    always_ff @(posedge clk) begin
        if (reset_i) begin
            rd_addr          <= '0;
            rd_incr          <= '0;
            wr_addr          <= '0;
            wr_incr          <= '0;
            other_even       <= '0;
            other_reg        <= XM_SYS_CTRL;
            intr_mask_o      <= `XM_INTR_MASK_RESET;
            intr_clear_o     <= '0;
            host_req_o.valid <= 1'b0;
            host_req_o.wr    <= 1'b0;
        end else begin
            host_req_o.valid <= 1'b0;
            intr_clear_o     <= '0;         // single-cycle pulse
            if (rd_done_i) begin
                rd_data <= rd_word_i;
                rd_addr <= rd_addr + rd_incr;
            end
            if (wr_done_i) begin
                wr_addr <= wr_addr + wr_incr;
            end
            // bus writes land after the increments and win on the same edge
            if (even_wr) begin
                case (bus_reg_num_i)
                    XM_RD_ADDR:         rd_addr[15:8] <= bus_data_i;
                    XM_WR_ADDR:         wr_addr[15:8] <= bus_data_i;
                    XM_DATA, XM_DATA_2: data_even     <= bus_data_i;
                    default: begin
                        other_even <= bus_data_i;
                        other_reg  <= bus_reg_num_i;
                    end
                endcase
            end
            if (odd_wr) begin
                case (bus_reg_num_i)
                    XM_SYS_CTRL: intr_mask_o  <= bus_data_i[3:0];
                    XM_TIMER:    intr_clear_o <= bus_data_i[3:0];
                    XM_RD_INCR:  rd_incr      <= {even_byte, bus_data_i};
                    XM_WR_INCR:  wr_incr      <= {even_byte, bus_data_i};
                    XM_WR_ADDR:  wr_addr[7:0] <= bus_data_i;
                    XM_RD_ADDR: begin
                        rd_addr[7:0]     <= bus_data_i;
                        host_req_o.valid <= 1'b1;       // fetch from new address
                        host_req_o.wr    <= 1'b0;
                        host_req_o.addr  <= {rd_addr[15:8], bus_data_i};
                    end
                    XM_DATA, XM_DATA_2: begin
                        host_req_o.valid <= 1'b1;
                        host_req_o.wr    <= 1'b1;
                        host_req_o.addr  <= wr_addr;
                        host_req_o.data  <= {data_even, bus_data_i};
                    end
                    default: ;
                endcase
            end
            if (odd_rd && (bus_reg_num_i == XM_DATA || bus_reg_num_i == XM_DATA_2)) begin
                host_req_o.valid <= 1'b1;       // prefetch next word
                host_req_o.wr    <= 1'b0;
                host_req_o.addr  <= rd_addr;
            end
        end
    end

    // one grant per edge in vram_port, so completions stay apart
    done_exclusive_a: assert property (@(posedge clk) disable iff (reset_i)
        !(rd_done_i && wr_done_i));

endmodule

//--- xm_settings.svh
// build constants for the video host port register block
`ifndef XM_SETTINGS_SVH
`define XM_SETTINGS_SVH

// word written over VRAM at boot, blue background with a white space
`define XM_CLEAR_DATA       16'h0220

// number of words cleared at boot
// a full 64K part clears all 65536 words, the short clear keeps runs quick
`define XM_CLEAR_WORDS      256

// timer tick period
`define XM_TIMER_DIV        10          // clk cycles per tick

// interrupt enables after reset
`define XM_INTR_MASK_RESET  4'h8        // only the top source enabled

`endif

//--- xm_top.sv
// host port top, register block beside the VRAM port, clear and timer
`timescale 1ns/1ns

module xm_top (
    input  logic             clk,
    input  logic             reset_i,
    input  logic             bus_wr_strobe_i,
    input  logic             bus_rd_strobe_i,
    input  xm_pkg::reg_num_t bus_reg_num_i,
    input  logic             bus_bytesel_i,
    input  xm_pkg::byte_t    bus_data_i,
    input  logic             vgen_sel_i,
    input  xm_pkg::word_t    vram_data_i,
    output xm_pkg::byte_t    bus_data_o,
    output logic             vram_sel_o,
    output logic             vram_wr_o,
    output xm_pkg::vaddr_t   vram_addr_o,
    output xm_pkg::word_t    vram_data_o,
    output xm_pkg::nib_t     intr_mask_o,
    output xm_pkg::nib_t     intr_clear_o
);
    import xm_pkg::*;

    vram_req_t host_req;
    vram_req_t clear_req;
    logic      clr_grant;
    logic      clr_busy;
    logic      rd_done;
    word_t     rd_word;
    logic      wr_done;
    word_t     timer_count;

    xm_reg_file xm_reg_file_inst (
        .clk, .reset_i, .bus_wr_strobe_i, .bus_rd_strobe_i, .bus_reg_num_i,
        .bus_bytesel_i, .bus_data_i,
        .busy_i(clr_busy), .timer_i(timer_count),
        .rd_done_i(rd_done), .rd_word_i(rd_word), .wr_done_i(wr_done),
        .bus_data_o, .host_req_o(host_req), .intr_mask_o, .intr_clear_o
    );

    vram_port vram_port_inst (
        .clk, .reset_i, .vgen_sel_i, .host_req_i(host_req), .clear_req_i(clear_req),
        .vram_data_i, .vram_sel_o, .vram_wr_o, .vram_addr_o, .vram_data_o,
        .grant_o(clr_grant), .rd_done_o(rd_done), .rd_word_o(rd_word), .wr_done_o(wr_done)
    );

    vram_clear vram_clear_inst (
        .clk, .reset_i, .grant_i(clr_grant), .clear_req_o(clear_req), .busy_o(clr_busy)
    );

    ms_timer ms_timer_inst (
        .clk, .reset_i, .count_o(timer_count)
    );

endmodule
